// ==== hdl/mem_bridge_pkg.sv ====
`default_nettype none

package mem_bridge_pkg;

	typedef logic lane_t;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} acc_size_t;

	// address word, read flat or as word index plus byte offset
	typedef union packed {
		logic [31:0] flat;
		struct packed {
			logic [29:0] index;
			logic [1:0]  offset;
		} word;
	} mem_addr_u;

	typedef struct packed {
		logic        valid;
		logic        write;
		acc_size_t   size;
		mem_addr_u   addr;
		logic [31:0] data;
	} lane_req_t;

	typedef struct packed {
		logic        valid;
		logic        write;
		logic [31:0] data;
	} lane_resp_t;

	// queue head after decode, store data already in its byte lanes
	typedef struct packed {
		logic        valid;
		lane_t       lane;
		logic        write;
		acc_size_t   size;
		mem_addr_u   addr;
		logic [31:0] data;
		logic [3:0]  strb;
	} issue_req_t;

	typedef struct packed {
		logic        valid;
		lane_t       lane;
		logic        write;
		acc_size_t   size;
		logic [1:0]  offset;
		logic [31:0] data;
	} done_t;

endpackage

`default_nettype wire

// ==== hdl/axi_bus_pkg.sv ====
`default_nettype none

package axi_bus_pkg;

	localparam int STRB_W = 4;

	////////////////////
	// address channels

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_ar_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_aw_t;

	////////////////////
	// data and response channels

	typedef struct packed {
		logic                  valid;
		logic [8*STRB_W-1:0]   data;
		logic [STRB_W-1:0]     strb;
		logic                  last;
	} axi_w_t;

	// single beat reads only
	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic        last;
	} axi_r_t;

	typedef struct packed {
		logic valid;
	} axi_b_t;

endpackage

`default_nettype wire

// ==== hdl/mem_req_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_req_decode #(
	parameter int REQ_CREDITS = 2
) (
	input  logic                       clk,
	input  logic                       reset,
	input  mem_bridge_pkg::lane_req_t  req [2],
	input  logic [1:0]                 pop,
	output mem_bridge_pkg::issue_req_t head [2],
	output logic [1:0]                 credit
);
	import mem_bridge_pkg::*;
	import axi_bus_pkg::*;

	localparam int PTR_W = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
	localparam int CNT_W = $clog2(REQ_CREDITS + 1);

	// credit goes back one cycle after the entry leaves
	always_ff @(posedge clk)
	begin
		if (reset)
			credit <= '0;
		else
			credit <= pop;
	end

	for (genvar i = 0; i < 2; i++)
	begin : g_lane
		lane_req_t         fifo [REQ_CREDITS];
		logic [PTR_W-1:0]  wr_ptr;
		logic [PTR_W-1:0]  rd_ptr;
		logic [CNT_W-1:0]  count;
		lane_req_t         entry;
		issue_req_t        dec;
		logic              force_word;

		////////////////////
		// circular queue

		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end
			else
			begin
				if (req[i].valid)
					wr_ptr <= (wr_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
				if (pop[i])
					rd_ptr <= (rd_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
				case ({req[i].valid, pop[i]})
					2'b10: count <= count + 1'b1;
					2'b01: count <= count - 1'b1;
					default: ;
				endcase
			end
		end

		always_ff @(posedge clk)
		begin
			if (req[i].valid)
				fifo[wr_ptr] <= req[i];
		end

		assign entry = fifo[rd_ptr];

		////////////////////
		// strobe and byte lane decode

		always_comb
		begin
			dec.valid  = (count != '0);
			dec.lane   = lane_t'(i);
			dec.write  = entry.write;
			dec.size   = entry.size;
			dec.addr   = entry.addr;
			dec.data   = entry.data;
			dec.strb   = '1;
			force_word = 1'b0;
			case (entry.size)
				SIZE_BYTE:
				begin
					dec.strb = STRB_W'(1) << entry.addr.word.offset;
					dec.data = entry.data << (8 * entry.addr.word.offset);
				end
				SIZE_HALF:
				begin
					if (!entry.addr.word.offset[0])
					begin
						dec.strb = entry.addr.word.offset[1] ? 4'b1100 : 4'b0011;
						dec.data = entry.data << (16 * entry.addr.word.offset[1]);
					end
					else
						force_word = 1'b1;
				end
				default:
					force_word = 1'b1;
			endcase
			// odd halves and every word access go out as an aligned full word
			if (force_word)
			begin
				dec.size             = SIZE_WORD;
				dec.addr.word.offset = 2'b00;
				dec.strb             = '1;
				dec.data             = entry.data;
			end
		end

		assign head[i] = dec;
	end

endmodule

`default_nettype wire

// ==== hdl/mem_bus_issue.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_bus_issue (
	input  logic                       clk,
	input  logic                       reset,
	input  mem_bridge_pkg::issue_req_t head [2],
	output logic [1:0]                 pop,
	output axi_bus_pkg::axi_ar_t       ar,
	output axi_bus_pkg::axi_aw_t       aw,
	output axi_bus_pkg::axi_w_t        w,
	input  logic                       arready,
	input  logic                       awready,
	input  logic                       wready,
	input  axi_bus_pkg::axi_r_t        r,
	input  axi_bus_pkg::axi_b_t        b,
	output mem_bridge_pkg::done_t      done
);
	import mem_bridge_pkg::*;
	import axi_bus_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE,
		ST_FWD
	} state_t;

	state_t      state;
	issue_req_t  sel;
	issue_req_t  cur;
	logic        start;
	logic        fwd_hit;
	logic        fwd_valid;
	logic [29:0] fwd_index;
	logic [31:0] fwd_data;
	logic        full_store;
	logic        beat;
	logic        ar_valid;
	logic        aw_valid;
	logic        w_valid;
	logic        done_valid;
	logic [31:0] done_data;

	// lane 0 wins whenever it has a head
	assign sel   = head[0].valid ? head[0] : head[1];
	assign start = (state == ST_IDLE) && sel.valid;

	// lane 1 word load of the word lane 0 last stored in full
	assign fwd_hit = fwd_valid && (sel.lane == 1'b1) && !sel.write
		&& (sel.size == SIZE_WORD) && (sel.addr.word.index == fwd_index);

	assign beat = ((state == ST_READ) && r.valid)
		|| ((state == ST_WRITE) && b.valid)
		|| (state == ST_FWD);

	assign pop = beat ? (2'b01 << cur.lane) : 2'b00;

	////////////////////
	// transaction sequencing

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (sel.valid)
						state <= fwd_hit ? ST_FWD : (sel.write ? ST_WRITE : ST_READ);
				ST_READ:
					if (r.valid)
						state <= ST_IDLE;
				ST_WRITE:
					if (b.valid)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// held until the transaction and its done are finished
	always_ff @(posedge clk)
	begin
		if (start)
			cur <= sel;
	end

	// each valid drops on its own handshake
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ar_valid <= 1'b0;
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
		end
		else if (start && !fwd_hit)
		begin
			ar_valid <= !sel.write;
			aw_valid <= sel.write;
			w_valid  <= sel.write;
		end
		else
		begin
			if (arready)
				ar_valid <= 1'b0;
			if (awready)
				aw_valid <= 1'b0;
			if (wready)
				w_valid <= 1'b0;
		end
	end

	assign ar = '{valid: ar_valid, addr: cur.addr.flat, size: {1'b0, cur.size}};
	assign aw = '{valid: aw_valid, addr: cur.addr.flat, size: {1'b0, cur.size}};
	assign w  = '{valid: w_valid, data: cur.data, strb: cur.strb, last: 1'b1};

	////////////////////
	// forwarding register

	assign full_store = (cur.lane == 1'b0) && (cur.size == SIZE_WORD);

	always_ff @(posedge clk)
	begin
		if (reset)
			fwd_valid <= 1'b0;
		else if ((state == ST_WRITE) && b.valid)
		begin
			if (full_store)
				fwd_valid <= 1'b1;
			else if (cur.addr.word.index == fwd_index)
				fwd_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == ST_WRITE) && b.valid && full_store)
		begin
			fwd_index <= cur.addr.word.index;
			fwd_data  <= cur.data;
		end
	end

	// done one cycle after the beat, cur still holds the entry
	always_ff @(posedge clk)
	begin
		if (reset)
			done_valid <= 1'b0;
		else
			done_valid <= beat;
	end

	always_ff @(posedge clk)
	begin
		if (beat)
			done_data <= (state == ST_FWD) ? fwd_data : r.data;
	end

	assign done = '{
		valid:  done_valid,
		lane:   cur.lane,
		write:  cur.write,
		size:   cur.size,
		offset: cur.addr.word.offset,
		data:   done_data
	};

endmodule

`default_nettype wire

// ==== hdl/mem_load_return.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_load_return (
	input  logic                       clk,
	input  logic                       reset,
	input  mem_bridge_pkg::done_t      done,
	output mem_bridge_pkg::lane_resp_t resp [2]
);
	import mem_bridge_pkg::*;
	import axi_bus_pkg::*;

	logic [8*STRB_W-1:0] shifted;
	logic [31:0]         load_data;

	// addressed byte lane moved down to bit 0
	assign shifted = done.data >> (8 * done.offset);

	always_comb
	begin
		case (done.size)
			SIZE_BYTE: load_data = {24'b0, shifted[7:0]};
			SIZE_HALF: load_data = {16'b0, shifted[15:0]};
			default:   load_data = shifted;
		endcase
		// stores only report completion
		if (done.write)
			load_data = '0;
	end

	////////////////////
	// per lane response registers

	for (genvar i = 0; i < 2; i++)
	begin : g_resp
		logic        hit;
		logic        valid_q;
		logic        write_q;
		logic [31:0] data_q;

		assign hit = done.valid && (done.lane == lane_t'(i));

		always_ff @(posedge clk)
		begin
			if (reset)
				valid_q <= 1'b0;
			else
				valid_q <= hit;
		end

		always_ff @(posedge clk)
		begin
			if (hit)
			begin
				write_q <= done.write;
				data_q  <= load_data;
			end
		end

		assign resp[i] = '{valid: valid_q, write: write_q, data: data_q};
	end

endmodule

`default_nettype wire

// ==== hdl/mem_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_bridge #(
	parameter int REQ_CREDITS = 2
) (
	input  logic                       clk,
	input  logic                       reset,
	input  mem_bridge_pkg::lane_req_t  req [2],
	output logic [1:0]                 credit,
	output mem_bridge_pkg::lane_resp_t resp [2],
	output axi_bus_pkg::axi_ar_t       ar,
	output axi_bus_pkg::axi_aw_t       aw,
	output axi_bus_pkg::axi_w_t        w,
	input  logic                       arready,
	input  logic                       awready,
	input  logic                       wready,
	input  axi_bus_pkg::axi_r_t        r,
	input  axi_bus_pkg::axi_b_t        b
);
	import mem_bridge_pkg::*;

	issue_req_t head [2];
	logic [1:0] pop;
	done_t      done;

	// lane queues and strobe decode
	mem_req_decode #(
		.REQ_CREDITS(REQ_CREDITS)
	) mem_req_decode_i (
		.clk    (clk),
		.reset  (reset),
		.req    (req),
		.pop    (pop),
		.head   (head),
		.credit (credit)
	);

	// arbitration and the single open bus transaction
	mem_bus_issue mem_bus_issue_i (
		.clk     (clk),
		.reset   (reset),
		.head    (head),
		.pop     (pop),
		.ar      (ar),
		.aw      (aw),
		.w       (w),
		.arready (arready),
		.awready (awready),
		.wready  (wready),
		.r       (r),
		.b       (b),
		.done    (done)
	);

	mem_load_return mem_load_return_i (
		.clk   (clk),
		.reset (reset),
		.done  (done),
		.resp  (resp)
	);

endmodule

`default_nettype wire

// ==== bench/mem_bridge_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_bridge_props (
	input logic        clk,
	input logic        reset,
	input logic        ar_valid,
	input logic        arready,
	input logic [31:0] ar_addr,
	input logic        aw_valid,
	input logic        awready,
	input logic [31:0] aw_addr,
	input logic        w_valid,
	input logic        wready,
	input logic [31:0] w_data,
	input logic        r_valid,
	input logic        b_valid,
	input logic        head0_valid,
	input logic        start,
	input logic [1:0]  pop,
	input logic [1:0]  credit
);
	int   fail_count = 0;
	logic open;
	logic lane0_pending;

	// a transaction is open from its first valid until the r or b beat
	always_ff @(posedge clk)
	begin
		if (reset)
			open <= 1'b0;
		else if (r_valid || b_valid)
			open <= 1'b0;
		else if (ar_valid || aw_valid)
			open <= 1'b1;
	end

	// lane 0 had a head when the open transaction was selected
	always_ff @(posedge clk)
	begin
		if (reset)
			lane0_pending <= 1'b0;
		else if (start)
			lane0_pending <= head0_valid;
	end

	////////////////////
	// channel rules

	a_ar_hold: assert property (@(posedge clk) disable iff (reset)
		ar_valid && !arready |=> ar_valid && $stable(ar_addr))
		else
		begin
			$error("ar dropped or changed before arready");
			fail_count++;
		end
	a_aw_hold: assert property (@(posedge clk) disable iff (reset)
		aw_valid && !awready |=> aw_valid && $stable(aw_addr))
		else
		begin
			$error("aw dropped or changed before awready");
			fail_count++;
		end
	a_w_hold: assert property (@(posedge clk) disable iff (reset)
		w_valid && !wready |=> w_valid && $stable(w_data))
		else
		begin
			$error("w dropped or changed before wready");
			fail_count++;
		end
	a_aw_w_pair: assert property (@(posedge clk) disable iff (reset)
		$rose(aw_valid) |-> $rose(w_valid))
		else
		begin
			$error("aw and w not raised together");
			fail_count++;
		end
	a_single_open: assert property (@(posedge clk) disable iff (reset)
		$rose(ar_valid) || $rose(aw_valid) |-> !open)
		else
		begin
			$error("new address while a transaction is open");
			fail_count++;
		end
	a_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !ar_valid && !aw_valid && !w_valid && credit == 2'b00)
		else
		begin
			$error("bus valid or credit high after reset");
			fail_count++;
		end

	////////////////////
	// arbitration

	a_lane0_first: assert property (@(posedge clk) disable iff (reset)
		lane0_pending && pop != 2'b00 |-> pop == 2'b01)
		else
		begin
			$error("lane 1 served while lane 0 had a head");
			fail_count++;
		end

endmodule

bind mem_bridge mem_bridge_props props_i (
	.clk         (clk),
	.reset       (reset),
	.ar_valid    (ar.valid),
	.arready     (arready),
	.ar_addr     (ar.addr),
	.aw_valid    (aw.valid),
	.awready     (awready),
	.aw_addr     (aw.addr),
	.w_valid     (w.valid),
	.wready      (wready),
	.w_data      (w.data),
	.r_valid     (r.valid),
	.b_valid     (b.valid),
	.head0_valid (head[0].valid),
	.start       (mem_bus_issue_i.start),
	.pop         (pop),
	.credit      (credit)
);

`default_nettype wire

// ==== bench/mem_bridge_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_bridge_tb;
	import mem_bridge_pkg::*;
	import axi_bus_pkg::*;

	localparam int REQ_CREDITS    = 2;
	localparam int NUM_RANDOM     = 60;
	// strobes, priority, forwarding and random tests
	localparam int TOTAL_REQS     = 3 * 4 * 2 + 4 * 2 + 2 + NUM_RANDOM;
	localparam int CYCLES_PER_REQ = 50;

	logic       clk = 1'b0;
	logic       reset;
	lane_req_t  req [2];
	logic [1:0] credit;
	lane_resp_t resp [2];
	axi_ar_t    ar;
	axi_aw_t    aw;
	axi_w_t     w;
	logic       arready;
	logic       awready;
	logic       wready;
	axi_r_t     r;
	axi_b_t     b;

	logic [31:0] rng = 32'd15;
	logic [31:0] mem [16];
	logic [31:0] ref_mem [16];
	lane_req_t   stim [2][$];
	lane_req_t   sb [2][$];
	int          cred [2];
	int          gap = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	logic        fwd_watch = 1'b0;
	logic [29:0] fwd_idx = '0;

	mem_bridge #(
		.REQ_CREDITS(REQ_CREDITS)
	) mem_bridge_i (
		.clk(clk), .reset(reset), .req(req), .credit(credit), .resp(resp),
		.ar(ar), .aw(aw), .w(w), .arready(arready), .awready(awready),
		.wready(wready), .r(r), .b(b)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	function automatic logic [3:0] expect_strb(logic [2:0] size, logic [1:0] off);
		case (size)
			3'd0: return 4'b0001 << off;
			3'd1: return (off == 2'd0) ? 4'b0011 : ((off == 2'd2) ? 4'b1100 : 4'b0000);
			3'd2: return (off == 2'd0) ? 4'b1111 : 4'b0000;
			default: return 4'b0000;
		endcase
	endfunction

	// misaligned halves and words read the whole aligned word
	function automatic logic [31:0] expect_load(logic [31:0] word, acc_size_t size,
		logic [1:0] off);
		if (size == SIZE_BYTE)
			return (word >> (8 * off)) & 32'hff;
		if (size == SIZE_HALF && !off[0])
			return (word >> (16 * off[1])) & 32'hffff;
		return word;
	endfunction

	// misaligned halves and words overwrite the whole aligned word
	function automatic logic [31:0] merge_store(logic [31:0] word, acc_size_t size,
		logic [1:0] off, logic [31:0] data);
		logic [31:0] res;
		res = word;
		if (size == SIZE_BYTE)
			res[8*off +: 8] = data[7:0];
		else if (size == SIZE_HALF && !off[0])
			res[16*off[1] +: 16] = data[15:0];
		else
			res = data;
		return res;
	endfunction

	function automatic logic ready_now();
		return (gap == 0) || ((next_rand() >> 8) % (gap + 1) == 0);
	endfunction

	task automatic queue_req(input int l, input logic write, input acc_size_t size,
		input logic [31:0] addr, input logic [31:0] data);
		lane_req_t n;
		n.valid     = 1'b1;
		n.write     = write;
		n.size      = size;
		n.addr.flat = addr;
		n.data      = data;
		stim[l].push_back(n);
	endtask

	task automatic finish_test(input string name);
		do
			@(posedge clk);
		while (stim[0].size() || stim[1].size() || sb[0].size() || sb[1].size()
			|| cred[0] != REQ_CREDITS || cred[1] != REQ_CREDITS);
		repeat (3) @(posedge clk);
		tests++;
		$display("test %-9s done: %0d checks, %0d errors so far", name, checks, errors);
	endtask

	////////////////////
	// lane drivers and credit counting

	always @(posedge clk)
	begin
		#2;
		for (int l = 0; l < 2; l++)
		begin
			if (credit[l])
				cred[l]++;
			req[l] = '0;
			if (stim[l].size() != 0 && cred[l] > 0)
			begin
				req[l] = stim[l].pop_front();
				sb[l].push_back(req[l]);
				cred[l]--;
			end
		end
	end

	////////////////////
	// bus slave model

	always @(posedge clk)
	begin
		static logic        rd_wait = 1'b0;
		static logic        aw_got = 1'b0;
		static logic        w_got = 1'b0;
		static int          rd_cnt = 0;
		static int          wr_cnt = 0;
		static logic [31:0] rd_addr = '0;
		static logic [31:0] wr_addr = '0;
		static logic [31:0] wr_data = '0;
		static logic [3:0]  wr_strb = '0;
		if (!reset)
		begin
			if (ar.valid && arready)
			begin
				rd_addr = ar.addr;
				rd_wait = 1'b1;
				rd_cnt  = (gap == 0) ? 0 : int'(next_rand() % gap);
			end
			if (aw.valid && awready)
			begin
				wr_addr = aw.addr;
				aw_got  = 1'b1;
				wr_cnt  = (gap == 0) ? 0 : int'(next_rand() % gap);
			end
			if (w.valid && wready)
			begin
				wr_data = w.data;
				wr_strb = w.strb;
				w_got   = 1'b1;
			end
		end
		#2;
		r = '0;
		b = '0;
		if (rd_wait)
		begin
			if (rd_cnt == 0)
			begin
				r       = '{valid: 1'b1, data: mem[rd_addr[5:2]], last: 1'b1};
				rd_wait = 1'b0;
			end
			else
				rd_cnt--;
		end
		if (aw_got && w_got)
		begin
			if (wr_cnt == 0)
			begin
				for (int i = 0; i < 4; i++)
					if (wr_strb[i])
						mem[wr_addr[5:2]][8*i +: 8] = wr_data[8*i +: 8];
				b.valid = 1'b1;
				aw_got  = 1'b0;
				w_got   = 1'b0;
			end
			else
				wr_cnt--;
		end
		arready = ready_now();
		awready = ready_now();
		wready  = ready_now();
	end

	////////////////////
	// response scoreboard

	always @(posedge clk)
	begin
		lane_req_t   q;
		logic [31:0] exp;
		if (!reset)
			for (int l = 0; l < 2; l++)
				if (resp[l].valid)
				begin
					if (sb[l].size() == 0)
					begin
						$display("lane %0d answered with no request outstanding", l);
						errors++;
					end
					else
					begin
						q   = sb[l].pop_front();
						exp = q.write ? 32'h0
							: expect_load(ref_mem[q.addr.flat[5:2]], q.size, q.addr.flat[1:0]);
						if (q.write)
							ref_mem[q.addr.flat[5:2]] = merge_store(ref_mem[q.addr.flat[5:2]],
								q.size, q.addr.flat[1:0], q.data);
						checks++;
						assert (resp[l].write == q.write)
						else
						begin
							$display("** Error: resp[%0d].write = %h, expected %h",
								l, resp[l].write, q.write);
							errors++;
						end
						assert (resp[l].data == exp)
						else
						begin
							$display("** Error: resp[%0d].data = %h, expected %h",
								l, resp[l].data, exp);
							errors++;
						end
					end
				end
	end

	a_strobe: assert property (@(posedge clk) disable iff (reset)
		w.valid && wready |-> w.strb == expect_strb(aw.size, aw.addr[1:0]))
		else
		begin
			$display("** Error: w.strb = %h, expected %h", $sampled(w.strb),
				expect_strb($sampled(aw.size), $sampled(aw.addr[1:0])));
			errors++;
		end

	a_w_last: assert property (@(posedge clk) disable iff (reset)
		w.valid && wready |-> w.last)
		else
		begin
			$display("w beat accepted without last set");
			errors++;
		end

	// reads go out only in shapes the strobe rule allows
	a_ar_shape: assert property (@(posedge clk) disable iff (reset)
		ar.valid && arready |-> expect_strb(ar.size, ar.addr[1:0]) != 4'b0000)
		else
		begin
			$display("** Error: ar.size = %h at ar.addr = %h is not an aligned access",
				$sampled(ar.size), $sampled(ar.addr));
			errors++;
		end

	a_credits: assert property (@(posedge clk) disable iff (reset)
		cred[0] >= 0 && cred[0] <= REQ_CREDITS && cred[1] >= 0 && cred[1] <= REQ_CREDITS)
		else
		begin
			$display("lane credit count left the range 0 to %0d", REQ_CREDITS);
			errors++;
		end

	// forwarded load must not reach the bus
	a_no_fwd_read: assert property (@(posedge clk) disable iff (reset)
		fwd_watch && ar.valid && arready |-> ar.addr[31:2] != fwd_idx)
		else
		begin
			$display("** Error: ar.addr = %h read during a forwarded load", $sampled(ar.addr));
			errors++;
		end

	initial
	begin
		#(TOTAL_REQS * CYCLES_PER_REQ * 20);
		$display("watchdog expired before all requests were answered");
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		logic [31:0] rnd;
		int          total;
		for (int i = 0; i < 16; i++)
		begin
			mem[i]     = (i + 1) * 32'h9e3779b1 ^ (i << 20);
			ref_mem[i] = mem[i];
		end
		reset   = 1'b1;
		req[0]  = '0;
		req[1]  = '0;
		arready = 1'b0;
		awready = 1'b0;
		wready  = 1'b0;
		r       = '0;
		b       = '0;
		cred[0] = REQ_CREDITS;
		cred[1] = REQ_CREDITS;
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;

		// store and load back each size at each offset
		for (int s = 0; s < 3; s++)
			for (int o = 0; o < 4; o++)
			begin
				queue_req(0, 1'b1, acc_size_t'(s), 32'((s * 4 + o) * 4 % 64 + o), next_rand());
				queue_req(0, 1'b0, acc_size_t'(s), 32'((s * 4 + o) * 4 % 64 + o), 32'h0);
			end
		finish_test("strobes");

		// both lanes queued together
		gap = 1;
		for (int i = 0; i < 4; i++)
		begin
			queue_req(0, i[0], SIZE_WORD, 32'(i * 8), next_rand());
			queue_req(1, !i[0], SIZE_HALF, 32'(i * 8 + 2), next_rand());
		end
		finish_test("priority");

		gap = 0;
		queue_req(0, 1'b1, SIZE_WORD, 32'h24, 32'hc0ffee15);
		finish_test("fwd_store");
		fwd_idx   = 30'h9;
		fwd_watch = 1'b1;
		queue_req(1, 1'b0, SIZE_WORD, 32'h24, 32'h0);
		finish_test("fwd_load");
		fwd_watch = 1'b0;

		// long ready gaps on every channel
		gap = 6;
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			rnd = next_rand();
			queue_req(int'(rnd[20]), rnd[21], acc_size_t'((rnd >> 24) % 3), rnd[5:0],
				next_rand());
		end
		finish_test("random");

		total = errors + mem_bridge_i.props_i.fail_count;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, total);
		if (total == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/mem_bridge_pkg.sv
hdl/axi_bus_pkg.sv
hdl/mem_req_decode.sv
hdl/mem_bus_issue.sv
hdl/mem_load_return.sv
hdl/mem_bridge.sv
bench/mem_bridge_props.sv
bench/mem_bridge_tb.sv

// ==== Makefile ====
TOP = mem_bridge_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f hdl/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
